//--- include/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// access operation codes
`define CSR_OP_NONE       2'd0
`define CSR_OP_WRITE      2'd1
`define CSR_OP_SET        2'd2
`define CSR_OP_CLEAR      2'd3

// machine-mode addresses
`define CSR_MSTATUS       12'h300
`define CSR_MTVEC         12'h305
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MHARTID       12'hF14

// performance counter window, 0x780 up to 0x79F
`define CSR_PCCR_BASE     12'h780
`define CSR_PCCR_ALL      12'h79F
`define CSR_PCER          12'h7A0
`define CSR_PCMR          12'h7A1

// mstatus fields that are kept
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7

// vectored trap mode
`define MTVEC_MODE        2'd1

`define N_PERF_COUNTERS   12
// global enable and saturate both on
`define PCMR_RESET        2'd3

// event bit positions
`define EV_CYCLE          0
`define EV_INSTR          1
`define EV_LD_STALL       2
`define EV_JR_STALL       3
`define EV_IMISS          4
`define EV_LOAD           5
`define EV_STORE          6
`define EV_JUMP           7
`define EV_BRANCH         8
`define EV_BRANCH_TAKEN   9
`define EV_COMPRESSED     10
`define EV_ELW_STALL      11

`endif

//--- src/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

  // register address and data
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // values from the CSR_OP_* macros
  typedef logic [1:0]  csr_op_t;

  // bit 5 flags an interrupt, bits 4:0 hold the code
  typedef logic [5:0]  cause_t;

  ////////////////////////////////////////
  // performance counters
  ////////////////////////////////////////

  // one bit per counter
  typedef logic [`N_PERF_COUNTERS-1:0] perf_vec_t;

  // low address bits inside the counter window
  typedef logic [4:0]  perf_idx_t;

  // bit 0 global enable, bit 1 saturate
  typedef logic [1:0]  perf_mode_t;

endpackage

//--- src/csr_access_ctrl.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_access_ctrl (
  input  csr_pkg::csr_op_t   csr_op_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  input  csr_pkg::csr_data_t mach_rdata_i,
  input  csr_pkg::csr_data_t perf_rdata_i,
  input  logic               perf_hit_i,
  output csr_pkg::csr_data_t rdata_o,
  output csr_pkg::csr_data_t wr_data_o,
  output logic               wr_en_o
);

  // perf window wins over the machine mux
  assign rdata_o = perf_hit_i ? perf_rdata_i : mach_rdata_i;

  // read-modify-write against the current read value
  always_comb begin
    wr_data_o = csr_wdata_i;
    wr_en_o   = 1'b1;
    case (csr_op_i)
      `CSR_OP_WRITE: wr_data_o = csr_wdata_i;
      `CSR_OP_SET:   wr_data_o = csr_wdata_i | rdata_o;
      `CSR_OP_CLEAR: wr_data_o = rdata_o & ~csr_wdata_i;
      // plain read, nothing to store
      default:       wr_en_o   = 1'b0;
    endcase
  end

endmodule

//--- src/csr_machine_regs.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_machine_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t wr_data_i,
  input  logic               wr_en_i,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  logic [23:0]        boot_addr_i,
  input  logic               csr_save_cause_i,
  input  logic               csr_save_if_i,
  input  logic               csr_save_id_i,
  input  csr_pkg::cause_t    csr_cause_i,
  input  csr_pkg::csr_data_t pc_if_i,
  input  csr_pkg::csr_data_t pc_id_i,
  input  logic               csr_restore_mret_i,
  output csr_pkg::csr_data_t rdata_o,
  output logic               m_irq_enable_o,
  output csr_pkg::csr_data_t mepc_o,
  output logic [23:0]        mtvec_o
);

  logic               mie_q;
  logic               mie_d;
  logic               mpie_q;
  logic               mpie_d;
  csr_pkg::csr_data_t mepc_q;
  csr_pkg::csr_data_t mepc_d;
  csr_pkg::cause_t    mcause_q;
  csr_pkg::cause_t    mcause_d;
  csr_pkg::csr_data_t exception_pc;

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    case (csr_addr_i)
      // only mie and mpie exist, mpp is implicitly machine
      `CSR_MSTATUS: begin
        rdata_o[`MSTATUS_MIE_BIT]  = mie_q;
        rdata_o[`MSTATUS_MPIE_BIT] = mpie_q;
      end
      `CSR_MTVEC:   rdata_o = {boot_addr_i, 6'h0, `MTVEC_MODE};
      `CSR_MEPC:    rdata_o = mepc_q;
      `CSR_MCAUSE:  rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      `CSR_MHARTID: rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:      rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    mie_d        = mie_q;
    mpie_d       = mpie_q;
    mepc_d       = mepc_q;
    mcause_d     = mcause_q;
    exception_pc = pc_id_i;

    if (wr_en_i) begin
      case (csr_addr_i)
        `CSR_MSTATUS: begin
          mie_d  = wr_data_i[`MSTATUS_MIE_BIT];
          mpie_d = wr_data_i[`MSTATUS_MPIE_BIT];
        end
        `CSR_MEPC:   mepc_d   = wr_data_i;
        `CSR_MCAUSE: mcause_d = {wr_data_i[31], wr_data_i[4:0]};
        default: ;
      endcase
    end

    // trap entry and mret override the CSR write above
    if (csr_save_cause_i) begin
      if (csr_save_if_i) begin
        exception_pc = pc_if_i;
      end
      mepc_d   = exception_pc;
      mcause_d = csr_cause_i;
      mpie_d   = mie_q;
      mie_d    = 1'b0;
    end else if (csr_restore_mret_i) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;
  // trap base comes straight from the boot address
  assign mtvec_o        = boot_addr_i;

endmodule

//--- src/perf_event_sel.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module perf_event_sel (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               id_valid_i,
  input  logic               is_decoding_i,
  input  logic               is_compressed_i,
  input  logic               imiss_i,
  input  logic               pc_set_i,
  input  logic               jump_i,
  input  logic               branch_i,
  input  logic               branch_taken_i,
  input  logic               ld_stall_i,
  input  logic               jr_stall_i,
  input  logic               pipeline_stall_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  output csr_pkg::perf_vec_t events_o
);

  // id stage completion of the previous cycle
  logic id_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= id_valid_i;
    end
  end

  assign events_o[`EV_CYCLE]        = 1'b1;
  assign events_o[`EV_INSTR]        = id_valid_i & is_decoding_i;
  assign events_o[`EV_LD_STALL]     = ld_stall_i & id_valid_q;
  assign events_o[`EV_JR_STALL]     = jr_stall_i & id_valid_q;
  // fetch wait cycles, jumps and branches excluded
  assign events_o[`EV_IMISS]        = imiss_i & ~pc_set_i;
  assign events_o[`EV_LOAD]         = mem_load_i;
  assign events_o[`EV_STORE]        = mem_store_i;
  assign events_o[`EV_JUMP]         = jump_i & id_valid_q;
  assign events_o[`EV_BRANCH]       = branch_i & id_valid_q;
  assign events_o[`EV_BRANCH_TAKEN] = branch_taken_i & id_valid_q;
  assign events_o[`EV_COMPRESSED]   = id_valid_i & is_decoding_i & is_compressed_i;
  // extra cycles spent in elw
  assign events_o[`EV_ELW_STALL]    = pipeline_stall_i;

endmodule

//--- src/perf_ctrl_regs.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module perf_ctrl_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_data_t  wr_data_i,
  input  logic                wr_en_i,
  input  csr_pkg::perf_vec_t  events_i,
  input  csr_pkg::csr_data_t  cnt_rdata_i,
  output logic                perf_hit_o,
  output csr_pkg::csr_data_t  perf_rdata_o,
  output csr_pkg::perf_vec_t  cnt_inc_o,
  output csr_pkg::perf_mode_t perf_mode_o,
  output logic                cnt_sel_valid_o,
  output logic                cnt_sel_all_o,
  output csr_pkg::perf_idx_t  cnt_sel_idx_o
);

  logic                is_pcer;
  logic                is_pcmr;
  csr_pkg::perf_vec_t  pcer_q;
  csr_pkg::perf_mode_t pcmr_q;

  // decode only for real accesses
  assign is_pcer         = csr_access_i && (csr_addr_i == `CSR_PCER);
  assign is_pcmr         = csr_access_i && (csr_addr_i == `CSR_PCMR);
  assign cnt_sel_valid_o = csr_access_i && ((csr_addr_i & 12'hFE0) == `CSR_PCCR_BASE);
  assign cnt_sel_all_o   = cnt_sel_valid_o && (csr_addr_i == `CSR_PCCR_ALL);
  assign cnt_sel_idx_o   = csr_addr_i[4:0];
  assign perf_hit_o      = is_pcer | is_pcmr | cnt_sel_valid_o;

  always_comb begin
    perf_rdata_o = '0;
    if (is_pcer) begin
      perf_rdata_o[`N_PERF_COUNTERS-1:0] = pcer_q;
    end else if (is_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end else if (cnt_sel_valid_o &&
                 (cnt_sel_idx_o < csr_pkg::perf_idx_t'(`N_PERF_COUNTERS))) begin
      // PCCR_ALL sits at index 31 and so reads zero
      perf_rdata_o = cnt_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= `PCMR_RESET;
    end else begin
      if (wr_en_i && is_pcer) begin
        pcer_q <= wr_data_i[`N_PERF_COUNTERS-1:0];
      end
      if (wr_en_i && is_pcmr) begin
        pcmr_q <= wr_data_i[1:0];
      end
    end
  end

  assign cnt_inc_o   = events_i & pcer_q & {`N_PERF_COUNTERS{pcmr_q[0]}};
  assign perf_mode_o = pcmr_q;

endmodule

//--- src/perf_counter_bank.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module perf_counter_bank (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::perf_vec_t  cnt_inc_i,
  input  csr_pkg::perf_mode_t perf_mode_i,
  input  logic                cnt_sel_valid_i,
  input  logic                cnt_sel_all_i,
  input  csr_pkg::perf_idx_t  cnt_sel_idx_i,
  input  csr_pkg::csr_data_t  wr_data_i,
  input  logic                wr_en_i,
  output csr_pkg::csr_data_t  cnt_rdata_o
);

  // increments land one cycle after the event
  csr_pkg::perf_vec_t inc_q;
  csr_pkg::csr_data_t cnt_q [`N_PERF_COUNTERS];
  csr_pkg::csr_data_t cnt_d [`N_PERF_COUNTERS];

  always_comb begin
    for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
      cnt_d[i] = cnt_q[i];
      // hold at all ones in saturate mode, wrap otherwise
      if (inc_q[i] && ((cnt_q[i] != '1) || !perf_mode_i[1])) begin
        cnt_d[i] = cnt_q[i] + 32'd1;
      end
      // a CSR write beats a pending increment
      if (wr_en_i && cnt_sel_valid_i &&
          (cnt_sel_all_i || (cnt_sel_idx_i == csr_pkg::perf_idx_t'(i)))) begin
        cnt_d[i] = wr_data_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inc_q <= '0;
      for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      inc_q <= cnt_inc_i;
      for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // indexed read, out of range gives zero
  always_comb begin
    cnt_rdata_o = '0;
    for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
      if (cnt_sel_idx_i == csr_pkg::perf_idx_t'(i)) begin
        cnt_rdata_o = cnt_q[i];
      end
    end
  end

endmodule

//--- src/csr_top.sv
`timescale 1ns/1ps

module csr_top (
  input  logic               clk,
  input  logic               rst_n,
  // CSR access port
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  input  csr_pkg::csr_op_t   csr_op_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  // ids and boot address
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  logic [23:0]        boot_addr_i,
  // trap control from the controller
  input  logic               csr_save_cause_i,
  input  logic               csr_save_if_i,
  input  logic               csr_save_id_i,
  input  csr_pkg::cause_t    csr_cause_i,
  input  csr_pkg::csr_data_t pc_if_i,
  input  csr_pkg::csr_data_t pc_id_i,
  input  logic               csr_restore_mret_i,
  // pipeline event strobes
  input  logic               id_valid_i,
  input  logic               is_decoding_i,
  input  logic               is_compressed_i,
  input  logic               imiss_i,
  input  logic               pc_set_i,
  input  logic               jump_i,
  input  logic               branch_i,
  input  logic               branch_taken_i,
  input  logic               ld_stall_i,
  input  logic               jr_stall_i,
  input  logic               pipeline_stall_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  // status to the core
  output logic               m_irq_enable_o,
  output csr_pkg::csr_data_t mepc_o,
  output logic [23:0]        mtvec_o
);

  csr_pkg::csr_data_t  mach_rdata;
  csr_pkg::csr_data_t  perf_rdata;
  logic                perf_hit;
  csr_pkg::csr_data_t  wr_data;
  logic                wr_en;
  csr_pkg::perf_vec_t  events;
  csr_pkg::perf_vec_t  cnt_inc;
  csr_pkg::perf_mode_t perf_mode;
  logic                cnt_sel_valid;
  logic                cnt_sel_all;
  csr_pkg::perf_idx_t  cnt_sel_idx;
  csr_pkg::csr_data_t  cnt_rdata;

  csr_access_ctrl u_access (
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .mach_rdata_i (mach_rdata),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .rdata_o      (csr_rdata_o),
    .wr_data_o    (wr_data),
    .wr_en_o      (wr_en)
  );

  csr_machine_regs u_mregs (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_addr_i         (csr_addr_i),
    .wr_data_i          (wr_data),
    .wr_en_i            (wr_en),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .boot_addr_i        (boot_addr_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_cause_i        (csr_cause_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .rdata_o            (mach_rdata),
    .m_irq_enable_o     (m_irq_enable_o),
    .mepc_o             (mepc_o),
    .mtvec_o            (mtvec_o)
  );

  ////////////////////////////////////////
  // performance counters
  ////////////////////////////////////////

  perf_event_sel u_events (
    .clk              (clk),
    .rst_n            (rst_n),
    .id_valid_i       (id_valid_i),
    .is_decoding_i    (is_decoding_i),
    .is_compressed_i  (is_compressed_i),
    .imiss_i          (imiss_i),
    .pc_set_i         (pc_set_i),
    .jump_i           (jump_i),
    .branch_i         (branch_i),
    .branch_taken_i   (branch_taken_i),
    .ld_stall_i       (ld_stall_i),
    .jr_stall_i       (jr_stall_i),
    .pipeline_stall_i (pipeline_stall_i),
    .mem_load_i       (mem_load_i),
    .mem_store_i      (mem_store_i),
    .events_o         (events)
  );

  perf_ctrl_regs u_pctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_access_i    (csr_access_i),
    .csr_addr_i      (csr_addr_i),
    .wr_data_i       (wr_data),
    .wr_en_i         (wr_en),
    .events_i        (events),
    .cnt_rdata_i     (cnt_rdata),
    .perf_hit_o      (perf_hit),
    .perf_rdata_o    (perf_rdata),
    .cnt_inc_o       (cnt_inc),
    .perf_mode_o     (perf_mode),
    .cnt_sel_valid_o (cnt_sel_valid),
    .cnt_sel_all_o   (cnt_sel_all),
    .cnt_sel_idx_o   (cnt_sel_idx)
  );

  perf_counter_bank u_pbank (
    .clk             (clk),
    .rst_n           (rst_n),
    .cnt_inc_i       (cnt_inc),
    .perf_mode_i     (perf_mode),
    .cnt_sel_valid_i (cnt_sel_valid),
    .cnt_sel_all_i   (cnt_sel_all),
    .cnt_sel_idx_i   (cnt_sel_idx),
    .wr_data_i       (wr_data),
    .wr_en_i         (wr_en),
    .cnt_rdata_o     (cnt_rdata)
  );

endmodule

//--- dv/csr_tb.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_tb;

  localparam int N_RAND_OPS     = 16;
  localparam int N_TRAPS        = 6;
  localparam int N_EVENT_CYCLES = 64;
  // cycle budget of all tests, used by the watchdog
  localparam int TOTAL_CYCLES   = 40 + 2 * N_RAND_OPS + 8 * N_TRAPS + N_EVENT_CYCLES + 120;

  logic                clk;
  logic                rst_n;
  logic                csr_access;
  csr_pkg::csr_addr_t  csr_addr;
  csr_pkg::csr_data_t  csr_wdata;
  csr_pkg::csr_op_t    csr_op;
  csr_pkg::csr_data_t  csr_rdata;
  logic [3:0]          core_id;
  logic [5:0]          cluster_id;
  logic [23:0]         boot_addr;
  logic                save_cause;
  logic                save_if;
  logic                save_id;
  csr_pkg::cause_t     cause;
  csr_pkg::csr_data_t  pc_if;
  csr_pkg::csr_data_t  pc_id;
  logic                restore_mret;
  logic                id_valid;
  logic                is_decoding;
  logic                is_compressed;
  logic                imiss;
  logic                pc_set;
  logic                jump;
  logic                branch;
  logic                branch_taken;
  logic                ld_stall;
  logic                jr_stall;
  logic                pipeline_stall;
  logic                mem_load;
  logic                mem_store;
  logic                m_irq_enable;
  csr_pkg::csr_data_t  mepc;
  logic [23:0]         mtvec;

  // reference model state
  logic                m_mie;
  logic                m_mpie;
  csr_pkg::csr_data_t  m_mepc;
  csr_pkg::cause_t     m_mcause;
  csr_pkg::perf_vec_t  m_pcer;
  csr_pkg::perf_mode_t m_pcmr;
  csr_pkg::perf_vec_t  m_inc;
  logic                m_idv_q;
  csr_pkg::csr_data_t  m_cnt [`N_PERF_COUNTERS];
  csr_pkg::csr_data_t  exp_rdata;
  csr_pkg::csr_data_t  exp_wd;
  logic                exp_we;
  csr_pkg::perf_vec_t  exp_events;
  logic [31:0]         lfsr_state;

  csr_top dut_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_access_i       (csr_access),
    .csr_addr_i         (csr_addr),
    .csr_wdata_i        (csr_wdata),
    .csr_op_i           (csr_op),
    .csr_rdata_o        (csr_rdata),
    .core_id_i          (core_id),
    .cluster_id_i       (cluster_id),
    .boot_addr_i        (boot_addr),
    .csr_save_cause_i   (save_cause),
    .csr_save_if_i      (save_if),
    .csr_save_id_i      (save_id),
    .csr_cause_i        (cause),
    .pc_if_i            (pc_if),
    .pc_id_i            (pc_id),
    .csr_restore_mret_i (restore_mret),
    .id_valid_i         (id_valid),
    .is_decoding_i      (is_decoding),
    .is_compressed_i    (is_compressed),
    .imiss_i            (imiss),
    .pc_set_i           (pc_set),
    .jump_i             (jump),
    .branch_i           (branch),
    .branch_taken_i     (branch_taken),
    .ld_stall_i         (ld_stall),
    .jr_stall_i         (jr_stall),
    .pipeline_stall_i   (pipeline_stall),
    .mem_load_i         (mem_load),
    .mem_store_i        (mem_store),
    .m_irq_enable_o     (m_irq_enable),
    .mepc_o             (mepc),
    .mtvec_o            (mtvec)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // expected read value for the current address
  always_comb begin
    exp_rdata = '0;
    if (csr_access && csr_addr == `CSR_PCER) begin
      exp_rdata = {20'b0, m_pcer};
    end else if (csr_access && csr_addr == `CSR_PCMR) begin
      exp_rdata = {30'b0, m_pcmr};
    end else if (csr_access && csr_addr[11:5] == 7'h3C) begin
      for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
        if (csr_addr[4:0] == 5'(i)) begin
          exp_rdata = m_cnt[i];
        end
      end
    end else begin
      case (csr_addr)
        `CSR_MSTATUS: exp_rdata = {24'b0, m_mpie, 3'b0, m_mie, 3'b0};
        `CSR_MTVEC:   exp_rdata = {boot_addr, 6'h0, 2'b01};
        `CSR_MEPC:    exp_rdata = m_mepc;
        `CSR_MCAUSE:  exp_rdata = {m_mcause[5], 26'b0, m_mcause[4:0]};
        `CSR_MHARTID: exp_rdata = {21'b0, cluster_id, 1'b0, core_id};
        default:      exp_rdata = '0;
      endcase
    end
  end

  always_comb begin
    exp_we = (csr_op != `CSR_OP_NONE);
    case (csr_op)
      `CSR_OP_SET:   exp_wd = csr_wdata | exp_rdata;
      `CSR_OP_CLEAR: exp_wd = exp_rdata & ~csr_wdata;
      default:       exp_wd = csr_wdata;
    endcase
  end

  always_comb begin
    exp_events                   = '0;
    exp_events[`EV_CYCLE]        = 1'b1;
    exp_events[`EV_INSTR]        = id_valid & is_decoding;
    exp_events[`EV_LD_STALL]     = ld_stall & m_idv_q;
    exp_events[`EV_JR_STALL]     = jr_stall & m_idv_q;
    exp_events[`EV_IMISS]        = imiss & ~pc_set;
    exp_events[`EV_LOAD]         = mem_load;
    exp_events[`EV_STORE]        = mem_store;
    exp_events[`EV_JUMP]         = jump & m_idv_q;
    exp_events[`EV_BRANCH]       = branch & m_idv_q;
    exp_events[`EV_BRANCH_TAKEN] = branch_taken & m_idv_q;
    exp_events[`EV_COMPRESSED]   = id_valid & is_decoding & is_compressed;
    exp_events[`EV_ELW_STALL]    = pipeline_stall;
  end

  // later assignments win, so traps and counter writes come last
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_mie    <= 1'b0;
      m_mpie   <= 1'b0;
      m_mepc   <= '0;
      m_mcause <= '0;
      m_pcer   <= '0;
      m_pcmr   <= 2'd3;
      m_inc    <= '0;
      m_idv_q  <= 1'b0;
      for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
        m_cnt[i] <= '0;
      end
    end else begin
      if (exp_we && csr_addr == `CSR_MSTATUS) begin
        m_mie  <= exp_wd[3];
        m_mpie <= exp_wd[7];
      end
      if (exp_we && csr_addr == `CSR_MEPC) begin
        m_mepc <= exp_wd;
      end
      if (exp_we && csr_addr == `CSR_MCAUSE) begin
        m_mcause <= {exp_wd[31], exp_wd[4:0]};
      end
      if (save_cause) begin
        m_mepc   <= save_if ? pc_if : pc_id;
        m_mcause <= cause;
        m_mpie   <= m_mie;
        m_mie    <= 1'b0;
      end else if (restore_mret) begin
        m_mie  <= m_mpie;
        m_mpie <= 1'b1;
      end
      if (exp_we && csr_access && csr_addr == `CSR_PCER) begin
        m_pcer <= exp_wd[11:0];
      end
      if (exp_we && csr_access && csr_addr == `CSR_PCMR) begin
        m_pcmr <= exp_wd[1:0];
      end
      for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
        if (m_inc[i] && (m_cnt[i] != 32'hFFFF_FFFF || !m_pcmr[1])) begin
          m_cnt[i] <= m_cnt[i] + 32'd1;
        end
        if (exp_we && csr_access && csr_addr[11:5] == 7'h3C &&
            (csr_addr[4:0] == 5'h1F || csr_addr[4:0] == 5'(i))) begin
          m_cnt[i] <= exp_wd;
        end
      end
      m_inc   <= exp_events & m_pcer & {`N_PERF_COUNTERS{m_pcmr[0]}};
      m_idv_q <= id_valid;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("mismatch %s: got %h, expected %h", name, got, want);
    fail_run();
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) csr_rdata == exp_rdata)
    else report_mismatch("csr_rdata_o", $sampled(csr_rdata), $sampled(exp_rdata));

  assert property (@(posedge clk) disable iff (!rst_n) mepc == m_mepc)
    else report_mismatch("mepc_o", $sampled(mepc), $sampled(m_mepc));

  assert property (@(posedge clk) disable iff (!rst_n) m_irq_enable == m_mie)
    else report_mismatch("m_irq_enable_o", {31'b0, $sampled(m_irq_enable)},
                         {31'b0, $sampled(m_mie)});

  // trap base follows the boot address
  assert property (@(posedge clk) disable iff (!rst_n) mtvec == boot_addr)
    else report_mismatch("mtvec_o", {8'b0, $sampled(mtvec)},
                         {8'b0, $sampled(boot_addr)});

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic clear_ctrl();
    csr_access   = 1'b0;
    csr_op       = `CSR_OP_NONE;
    csr_addr     = '0;
    csr_wdata    = '0;
    save_cause   = 1'b0;
    save_if      = 1'b0;
    save_id      = 1'b0;
    cause        = '0;
    pc_if        = '0;
    pc_id        = '0;
    restore_mret = 1'b0;
  endtask

  task automatic set_strobes(input logic [12:0] b);
    {id_valid, is_decoding, is_compressed, imiss, pc_set, jump, branch} = b[12:6];
    {branch_taken, ld_stall, jr_stall, pipeline_stall, mem_load, mem_store} = b[5:0];
  endtask

  task automatic csr_cycle(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                           input csr_pkg::csr_data_t data);
    @(negedge clk);
    clear_ctrl();
    csr_access = 1'b1;
    csr_op     = op;
    csr_addr   = addr;
    csr_wdata  = data;
  endtask

  task automatic csr_read(input csr_pkg::csr_addr_t addr);
    csr_cycle(`CSR_OP_NONE, addr, 32'h0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_ctrl();
    end
  endtask

  task automatic random_events(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_ctrl();
      set_strobes(13'(rand_bits(13)));
    end
    @(negedge clk);
    set_strobes('0);
  endtask

  task automatic read_all_counters();
    for (int i = 0; i < `N_PERF_COUNTERS; i++) begin
      csr_read(csr_pkg::csr_addr_t'(`CSR_PCCR_BASE + i));
    end
  endtask

  // trap entry together with a CSR write to the same registers
  task automatic trap_with_write(input csr_pkg::csr_addr_t addr);
    logic [31:0] r;
    r = rand_bits(1);
    csr_cycle(`CSR_OP_WRITE, addr, rand_bits(32));
    save_cause = 1'b1;
    save_if    = r[0];
    save_id    = ~r[0];
    cause      = csr_pkg::cause_t'(rand_bits(6));
    pc_if      = rand_bits(32);
    pc_id      = rand_bits(32);
  endtask

  task automatic mret_with_write();
    csr_cycle(`CSR_OP_WRITE, `CSR_MSTATUS, rand_bits(32));
    restore_mret = 1'b1;
  endtask

  initial begin
    #(TOTAL_CYCLES * 40 + 1000);
    $display("timeout: the tests did not finish within the expected time");
    fail_run();
  end

  initial begin
    logic [31:0]        r;
    csr_pkg::csr_addr_t a;
    clk        = 1'b0;
    rst_n      = 1'b0;
    lfsr_state = 32'h743cb503;
    core_id    = 4'h9;
    cluster_id = 6'h2D;
    boot_addr  = 24'h1C0080;
    clear_ctrl();
    set_strobes('0);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // reset values and constant registers
    csr_read(`CSR_MSTATUS);
    csr_read(`CSR_MEPC);
    csr_read(`CSR_MCAUSE);
    csr_read(`CSR_PCMR);
    csr_read(`CSR_PCER);
    csr_read(`CSR_MHARTID);
    csr_read(`CSR_MTVEC);
    csr_read(`CSR_PCCR_ALL);
    csr_read(12'h78C);

    // write, set and clear with random data
    for (int n = 0; n < N_RAND_OPS; n++) begin
      r = rand_bits(3);
      a = r[2] ? `CSR_MEPC : `CSR_MSTATUS;
      csr_cycle((r[1:0] == 2'd0) ? `CSR_OP_WRITE : r[1:0], a, rand_bits(32));
      csr_read(a);
    end

    // trap entry against colliding writes, then mret
    for (int n = 0; n < N_TRAPS; n++) begin
      // random mie and mpie going into the trap
      csr_cycle(`CSR_OP_WRITE, `CSR_MSTATUS, rand_bits(32));
      case (n % 3)
        0:       trap_with_write(`CSR_MEPC);
        1:       trap_with_write(`CSR_MCAUSE);
        default: trap_with_write(`CSR_MSTATUS);
      endcase
      csr_read(`CSR_MEPC);
      csr_read(`CSR_MCAUSE);
      csr_read(`CSR_MSTATUS);
      mret_with_write();
      csr_read(`CSR_MSTATUS);
    end

    // load, store and taken-branch counters
    csr_cycle(`CSR_OP_WRITE, `CSR_PCER, 32'h0000_0260);
    random_events(N_EVENT_CYCLES);
    csr_cycle(`CSR_OP_WRITE, `CSR_PCER, 32'h0);
    idle_cycles(2);
    read_all_counters();

    // saturate, then wrap
    csr_cycle(`CSR_OP_WRITE, `CSR_PCER, 32'h1);
    csr_cycle(`CSR_OP_WRITE, `CSR_PCCR_BASE, 32'hFFFF_FFFE);
    idle_cycles(4);
    csr_read(`CSR_PCCR_BASE);
    csr_cycle(`CSR_OP_CLEAR, `CSR_PCMR, 32'h2);
    csr_cycle(`CSR_OP_WRITE, `CSR_PCCR_BASE, 32'hFFFF_FFFE);
    idle_cycles(3);
    csr_read(`CSR_PCCR_BASE);

    // write-all, then frozen with the global enable off
    csr_cycle(`CSR_OP_WRITE, `CSR_PCMR, 32'h0);
    csr_cycle(`CSR_OP_WRITE, `CSR_PCER, 32'h0000_0FFF);
    idle_cycles(2);
    csr_cycle(`CSR_OP_WRITE, `CSR_PCCR_ALL, 32'h0);
    random_events(16);
    read_all_counters();

    idle_cycles(2);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
src/csr_pkg.sv
src/csr_access_ctrl.sv
src/csr_machine_regs.sv
src/perf_event_sel.sv
src/perf_ctrl_regs.sv
src/perf_counter_bank.sv
src/csr_top.sv
dv/csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := csr_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard src/*.sv dv/*.sv include/*.svh) $(FILELIST)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
